// ==== hdl/ucs_macros.svh ====
// sizing macros for the unsat clause selector, included by the package and by RTL that sizes arrays
`ifndef UCS_MACROS_SVH
`define UCS_MACROS_SVH

// clause buffer depth in entries
`define UCS_DEPTH 2048

// random slice N taken from the 32-bit prng word
`define UCS_RAN_W 18
`define UCS_RAN_OFFSET 10 // low bit of the slice

// fraction bits of the 1/m reciprocal
`define UCS_RECIP_W 32

// clause format, NSAT literal addresses per word
`define UCS_NSAT 3
`define UCS_LIT_W 12

`endif

// ==== hdl/ucs_pkg.sv ====
// shared types for the unsat clause selector, imported by every RTL block and the testbench
`default_nettype none

`include "ucs_macros.svh"

package ucs_pkg;

    typedef logic [`UCS_NSAT*`UCS_LIT_W-1:0] clause_t;      // packed literal addresses
    typedef logic [$clog2(`UCS_DEPTH)-1:0]   buf_addr_t;    // slot in the buffer
    typedef logic [$clog2(`UCS_DEPTH):0]     buf_count_t;   // 0..DEPTH inclusive
    typedef logic [`UCS_RECIP_W-1:0]         recip_t;       // all fraction bits
    typedef logic [`UCS_RAN_W-1:0]           rand_slice_t;  // N

    // what port A of the clause ram does in a given cycle
    typedef enum logic [2:0] {
        OP_IDLE         = 3'd0, // port A off
        OP_LOAD         = 3'd1, // setup write at setup address
        OP_APPEND       = 3'd2, // fifo clause to slot count
        OP_REPLACE_FIFO = 3'd3, // selected slot <- fifo clause
        OP_REPLACE_LAST = 3'd4, // selected slot <- tail clause, shrink
        OP_REMOVE_LAST  = 3'd5  // selected slot is the tail, read and shrink
    } buf_op_t;

endpackage

`default_nettype wire

// ==== hdl/recip_table.sv ====
// rom of rounded-up 1/m fractions, addressed by the clause count, one cycle read latency
`timescale 1ns/10ps
`default_nettype none

`include "ucs_macros.svh"

module recip_table (
    input  wire logic                clk,
    input  wire ucs_pkg::buf_count_t addr_i, // m
    output ucs_pkg::recip_t          data_o  // ceil(2^RECIP_W / m), valid next cycle
);
    import ucs_pkg::*;

    localparam int ENTRIES = `UCS_DEPTH + 1; // m runs 0..DEPTH

    recip_t rom [ENTRIES];

    // ceil(2^W / m); m = 0 gives 0, m = 1 would need W+1 bits so it saturates
    // the pipeline never uses either of those two entries
    function automatic recip_t recip_ceil(input int unsigned m);
        longint unsigned full;
        longint unsigned q;
        full = longint'(1) << `UCS_RECIP_W;
        if (m == 0)
            return '0;
        q = (full + longint'(m) - 1) / longint'(m); // round up, keeps N*r/2^W from falling short
        if (q >= full)
            return '1;
        return recip_t'(q);
    endfunction

    initial begin
        for (int i = 0; i < ENTRIES; i++) begin
            rom[i] = recip_ceil(i);
        end
    end

    always_ff @(posedge clk) begin
        data_o <= rom[addr_i]; // plain registered read
    end

endmodule

`default_nettype wire

// ==== hdl/mod_index_pipe.sv ====
// three-stage N mod m pipeline that hands the buffer control its selection index
`timescale 1ns/10ps
`default_nettype none

`include "ucs_macros.svh"

module mod_index_pipe (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                request_i,    // one-cycle pulse
    input  wire logic [31:0]         random_i,     // prng word
    input  wire ucs_pkg::buf_count_t count_i,      // live clause count
    output ucs_pkg::buf_count_t      recip_addr_o, // to recip_table
    input  wire ucs_pkg::recip_t     recip_data_i, // one cycle after recip_addr_o
    output logic                     sel_valid_o,
    output ucs_pkg::buf_addr_t       sel_index_o
);
    import ucs_pkg::*;

    localparam int RAN_W  = `UCS_RAN_W;
    localparam int REC_W  = `UCS_RECIP_W;
    localparam int CNT_W  = $bits(buf_count_t);
    localparam int ADDR_W = $bits(buf_addr_t);

    // stage 1 holds N, m and valid
    rand_slice_t n1;
    buf_count_t  m1;
    logic        v1;
    // stage 2 holds the product
    rand_slice_t              n2;
    buf_count_t               m2;
    logic [RAN_W+REC_W-1:0]   prod2;
    logic                     v2;
    // stage 3 holds the index
    buf_count_t  m3;  // kept for the range check
    buf_addr_t   idx3;
    logic        v3;

    // correction terms off the stage 2 registers
    rand_slice_t            quot2;
    logic [RAN_W+CNT_W-1:0] qm2;
    rand_slice_t            rem2;

    // table is read with the count the request sees, so data lines up with m1
    assign recip_addr_o = count_i;

    assign quot2 = prod2[REC_W +: RAN_W];   // floor(N / m)
    assign qm2   = quot2 * m2;
    assign rem2  = n2 - qm2[RAN_W-1:0];     // N - q*m stays below m as r rounds up

    // a request that sees m = 0 dies after stage 1
    always_ff @(posedge clk) begin
        if (reset) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else begin
            v1 <= request_i;
            v2 <= v1 && (m1 != '0);
            v3 <= v2;
        end
    end

    // data registers ride along with the valid chain
    always_ff @(posedge clk) begin
        n1    <= random_i[`UCS_RAN_OFFSET +: RAN_W];
        m1    <= count_i;
        n2    <= n1;
        m2    <= m1;
        prod2 <= n1 * recip_data_i;            // N * ceil(2^W/m)
        m3    <= m2;
        if (m2 == buf_count_t'(1))
            idx3 <= '0;                        // 1/1 does not fit the table
        else
            idx3 <= rem2[ADDR_W-1:0];
    end

    assign sel_valid_o = v3;
    assign sel_index_o = idx3;

    // index must land inside the buffer the request saw
    a_index_in_range: assert property (@(posedge clk) disable iff (reset)
        v3 |-> (buf_count_t'(idx3) < m3));

    // one request in flight per count update
    a_request_spacing: assert property (@(posedge clk) disable iff (reset)
        request_i |=> !request_i [*3]);

endmodule

`default_nettype wire

// ==== hdl/unsat_buffer_ctrl.sv ====
// port-A decode for the clause ram plus the clause count and sticky overflow flag
`timescale 1ns/10ps
`default_nettype none

`include "ucs_macros.svh"

module unsat_buffer_ctrl (
    input  wire logic                clk,
    input  wire logic                reset,
    // setup load
    input  wire logic                setup_i,          // level
    input  wire logic                ucb_setup_wren_i,
    input  wire ucs_pkg::buf_addr_t  ucb_setup_addr_i, // 0,1,2.. in order
    input  wire ucs_pkg::clause_t    ucb_setup_data_i,
    // run side
    input  wire logic                write_disable_i,  // blocks appends only
    input  wire logic                fifo_empty_i,
    input  wire ucs_pkg::clause_t    fifo_clause_i,
    input  wire logic                sel_valid_i,
    input  wire ucs_pkg::buf_addr_t  sel_index_i,
    input  wire ucs_pkg::clause_t    last_clause_i,    // ram port B at count-1
    // ram port A
    output logic                     ram_en_o,
    output logic                     ram_we_o,
    output ucs_pkg::buf_addr_t       ram_addr_o,
    output ucs_pkg::clause_t         ram_wdata_o,
    output ucs_pkg::buf_addr_t       last_addr_o,
    output logic                     read_strobe_o,    // selected slot read this cycle
    output ucs_pkg::buf_count_t      count_o,
    output logic                     overflow_o
);
    import ucs_pkg::*;

    localparam buf_count_t DEPTH_C = buf_count_t'(`UCS_DEPTH);

    buf_op_t   op;
    logic      full;
    logic      drop;      // load/append refused, buffer full
    buf_addr_t last_addr;

    assign full        = (count_o == DEPTH_C);
    assign last_addr   = buf_addr_t'(count_o - 1'b1); // wraps at count 0, never used there
    assign last_addr_o = last_addr;

    // setup beats everything, then a selection, then an append
    always_comb begin
        op   = OP_IDLE;
        drop = 1'b0;
        if (setup_i) begin
            if (ucb_setup_wren_i) begin
                if (full)
                    drop = 1'b1;
                else
                    op = OP_LOAD;
            end
        end else if (sel_valid_i) begin
            if (!fifo_empty_i)
                op = OP_REPLACE_FIFO;            // refill from fifo, count holds
            else if (sel_index_i == last_addr)
                op = OP_REMOVE_LAST;             // tail picked, nothing to move
            else
                op = OP_REPLACE_LAST;            // swap tail into the hole
        end else if (!fifo_empty_i && !write_disable_i) begin
            if (full)
                drop = 1'b1;
            else
                op = OP_APPEND;
        end
    end

    // port A mux
    always_comb begin
        ram_en_o    = (op != OP_IDLE);
        ram_we_o    = 1'b0;
        ram_addr_o  = sel_index_i;
        ram_wdata_o = fifo_clause_i;
        case (op)
            OP_LOAD: begin
                ram_we_o    = 1'b1;
                ram_addr_o  = ucb_setup_addr_i;
                ram_wdata_o = ucb_setup_data_i;
            end
            OP_APPEND: begin
                ram_we_o   = 1'b1;
                ram_addr_o = buf_addr_t'(count_o); // first free slot
            end
            OP_REPLACE_FIFO: ram_we_o = 1'b1;
            OP_REPLACE_LAST: begin
                ram_we_o    = 1'b1;
                ram_wdata_o = last_clause_i;
            end
            default: ; // idle, or remove-last which only reads
        endcase
    end

    assign read_strobe_o = (op == OP_REPLACE_FIFO) || (op == OP_REPLACE_LAST) ||
                           (op == OP_REMOVE_LAST);

    // count and overflow
    always_ff @(posedge clk) begin
        if (reset) begin
            count_o    <= '0;
            overflow_o <= 1'b0;
        end else begin
            case (op)
                OP_LOAD, OP_APPEND:              count_o <= count_o + 1'b1;
                OP_REPLACE_LAST, OP_REMOVE_LAST: count_o <= count_o - 1'b1;
                default: ;
            endcase
            if (drop)
                overflow_o <= 1'b1; // sticky
        end
    end

    a_count_bounded: assert property (@(posedge clk) disable iff (reset)
        count_o <= DEPTH_C);

    // a selection that shrinks the buffer needs something in it
    a_no_remove_empty: assert property (@(posedge clk) disable iff (reset)
        (op == OP_REPLACE_LAST || op == OP_REMOVE_LAST) |-> (count_o != '0));

endmodule

`default_nettype wire

// ==== hdl/unsat_clause_ram.sv ====
// dual-port clause buffer, port A read-first read/write, port B tail read, registered output
`timescale 1ns/10ps
`default_nettype none

`include "ucs_macros.svh"

module unsat_clause_ram (
    input  wire logic               clk,
    input  wire logic               reset,
    // port A, load / append / replace
    input  wire logic               en_a_i,
    input  wire logic               we_a_i,
    input  wire ucs_pkg::buf_addr_t addr_a_i,
    input  wire ucs_pkg::clause_t   din_a_i,
    // port B, tail of the buffer
    input  wire ucs_pkg::buf_addr_t addr_b_i,
    output ucs_pkg::clause_t        dout_b_o,
    // output side
    input  wire logic               read_strobe_i,
    output ucs_pkg::clause_t        dout_a_o,       // old contents of the written slot
    output logic                    dout_a_valid_o
);
    import ucs_pkg::*;

    clause_t mem [`UCS_DEPTH];

    // read-first, dout gets the slot before this cycle's write
    always_ff @(posedge clk) begin
        if (en_a_i) begin
            if (we_a_i)
                mem[addr_a_i] <= din_a_i;
            dout_a_o <= mem[addr_a_i];
        end
    end

    // tail read follows the count in the same cycle
    // so a refill in the selection cycle sees an append from the cycle before
    assign dout_b_o = mem[addr_b_i];

    // one-cycle strobe that marks dout_a_o as a selection
    always_ff @(posedge clk) begin
        if (reset)
            dout_a_valid_o <= 1'b0;
        else
            dout_a_valid_o <= read_strobe_i;
    end

endmodule

`default_nettype wire

// ==== hdl/unsat_clause_selector.sv ====
// top of the unsat clause selector, ties index pipeline, reciprocal rom, control and ram
`timescale 1ns/10ps
`default_nettype none

module unsat_clause_selector (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                setup_i,
    input  wire logic                ucb_setup_wren_i,
    input  wire ucs_pkg::buf_addr_t  ucb_setup_addr_i,
    input  wire ucs_pkg::clause_t    ucb_setup_data_i,
    input  wire logic                request_i,
    input  wire logic                write_disable_i,
    input  wire logic                fifo_empty_i,
    input  wire ucs_pkg::clause_t    fifo_clause_i,
    input  wire logic [31:0]         random_i,
    output ucs_pkg::buf_count_t      buffer_count_o,
    output ucs_pkg::clause_t         selected_o,
    output logic                     selected_valid_o,
    output logic                     ucb_overflow_o
);
    import ucs_pkg::*;

    buf_count_t recip_addr;  // m for the rom
    recip_t     recip_data;
    logic       sel_valid;
    buf_addr_t  sel_index;
    logic       ram_en;
    logic       ram_we;
    buf_addr_t  ram_addr;
    clause_t    ram_wdata;
    buf_addr_t  last_addr;   // count-1
    clause_t    last_clause;
    logic       read_strobe;

    recip_table recip_table_i (
        .clk    (clk),
        .addr_i (recip_addr),
        .data_o (recip_data)
    );

    mod_index_pipe mod_index_pipe_i (
        .clk          (clk),
        .reset        (reset),
        .request_i    (request_i),
        .random_i     (random_i),
        .count_i      (buffer_count_o),
        .recip_addr_o (recip_addr),
        .recip_data_i (recip_data),
        .sel_valid_o  (sel_valid),
        .sel_index_o  (sel_index)
    );

    unsat_buffer_ctrl unsat_buffer_ctrl_i (
        .clk              (clk),
        .reset            (reset),
        .setup_i          (setup_i),
        .ucb_setup_wren_i (ucb_setup_wren_i),
        .ucb_setup_addr_i (ucb_setup_addr_i),
        .ucb_setup_data_i (ucb_setup_data_i),
        .write_disable_i  (write_disable_i),
        .fifo_empty_i     (fifo_empty_i),
        .fifo_clause_i    (fifo_clause_i),
        .sel_valid_i      (sel_valid),
        .sel_index_i      (sel_index),
        .last_clause_i    (last_clause),
        .ram_en_o         (ram_en),
        .ram_we_o         (ram_we),
        .ram_addr_o       (ram_addr),
        .ram_wdata_o      (ram_wdata),
        .last_addr_o      (last_addr),
        .read_strobe_o    (read_strobe),
        .count_o          (buffer_count_o),
        .overflow_o       (ucb_overflow_o)
    );

    unsat_clause_ram unsat_clause_ram_i (
        .clk            (clk),
        .reset          (reset),
        .en_a_i         (ram_en),
        .we_a_i         (ram_we),
        .addr_a_i       (ram_addr),
        .din_a_i        (ram_wdata),
        .addr_b_i       (last_addr),
        .dout_b_o       (last_clause),
        .read_strobe_i  (read_strobe),
        .dout_a_o       (selected_o),
        .dout_a_valid_o (selected_valid_o)
    );

endmodule

`default_nettype wire

// ==== tb/tb_unsat_clause_selector.sv ====
// self-checking testbench for the unsat clause selector, plays prng, clause fifo and solver
`timescale 1ns/10ps
`default_nettype none

`include "ucs_macros.svh"

module tb_unsat_clause_selector;
    import ucs_pkg::*;

    localparam int DEPTH = `UCS_DEPTH;

    logic        clk = 1'b0;
    logic        reset;
    logic        setup_i;
    logic        ucb_setup_wren_i;
    buf_addr_t   ucb_setup_addr_i;
    clause_t     ucb_setup_data_i;
    logic        request_i;
    logic        write_disable_i;
    logic        fifo_empty_i;
    clause_t     fifo_clause_i;
    logic [31:0] random_i;
    buf_count_t  buffer_count_o;
    clause_t     selected_o;
    logic        selected_valid_o;
    logic        ucb_overflow_o;

    clause_t model[$];   // buffer contents, index = slot
    clause_t exp_sel[$]; // selections still to come out
    bit      overflow_exp = 1'b0;
    int      err_value = 0;
    int      err_other = 0;

    unsat_clause_selector unsat_clause_selector_i (
        .clk              (clk),
        .reset            (reset),
        .setup_i          (setup_i),
        .ucb_setup_wren_i (ucb_setup_wren_i),
        .ucb_setup_addr_i (ucb_setup_addr_i),
        .ucb_setup_data_i (ucb_setup_data_i),
        .request_i        (request_i),
        .write_disable_i  (write_disable_i),
        .fifo_empty_i     (fifo_empty_i),
        .fifo_clause_i    (fifo_clause_i),
        .random_i         (random_i),
        .buffer_count_o   (buffer_count_o),
        .selected_o       (selected_o),
        .selected_valid_o (selected_valid_o),
        .ucb_overflow_o   (ucb_overflow_o)
    );

    always #20 clk = ~clk; // 40 ns period

    function automatic clause_t rand_clause();
        logic [63:0] r;
        r = {$urandom, $urandom};
        return clause_t'(r);
    endfunction

    // N mod m straight from the definition
    function automatic int ref_mod(input rand_slice_t n, input int m);
        return int'(n) % m;
    endfunction

    task automatic check_clause(input string name, input clause_t got, input clause_t exp);
        if (got !== exp) begin
            err_value++;
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input buf_count_t got, input buf_count_t exp);
        if (got !== exp) begin
            err_value++;
            $display("ERR t=%0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            err_value++;
            $display("ERR t=%0t %s got %0b exp %0b", $time, name, got, exp);
        end
    endtask

    // refill rule: fifo clause if pending, else tail moves into the hole
    task automatic apply_select(input int idx, input logic fifo_empty, input clause_t fifo_c);
        int last;
        last = model.size() - 1;
        if (!fifo_empty)
            model[idx] = fifo_c;
        else if (idx == last)
            void'(model.pop_back()); // tail picked
        else
            model[idx] = model.pop_back();
    endtask

    // every selected_valid_o pulse must match the oldest outstanding selection
    always @(negedge clk) begin
        if (!reset && selected_valid_o) begin
            if (exp_sel.size() == 0) begin
                err_other++;
                $display("selected_valid_o rose at %0t with no selection outstanding", $time);
            end else begin
                check_clause("selected_o", selected_o, exp_sel.pop_front());
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #2; // drive point
    endtask

    task automatic load_buffer(input int n);
        clause_t c;
        setup_i = 1'b1;
        for (int i = 0; i < n; i++) begin
            c = rand_clause();
            ucb_setup_wren_i = 1'b1;
            ucb_setup_addr_i = buf_addr_t'(i); // strictly in order
            ucb_setup_data_i = c;
            model.push_back(c);
            step();
        end
        ucb_setup_wren_i = 1'b0;
        setup_i = 1'b0;
        step();
        check_count("buffer_count_o", buffer_count_o, buf_count_t'(model.size()));
    endtask

    // one selection with the current fifo state held through the pipeline
    task automatic do_request(input rand_slice_t n);
        logic [31:0] word;
        int          idx;
        int          waited;
        word = $urandom;
        word[`UCS_RAN_OFFSET +: `UCS_RAN_W] = n;
        idx = ref_mod(n, model.size());
        exp_sel.push_back(model[idx]);
        apply_select(idx, fifo_empty_i, fifo_clause_i);
        random_i  = word;
        request_i = 1'b1;
        step();
        request_i = 1'b0;
        waited = 0;
        while (exp_sel.size() != 0 && waited < 12) begin
            @(negedge clk);
            #1; // after the compare process
            waited++;
        end
        if (exp_sel.size() != 0) begin
            err_other++;
            $display("timeout at %0t waiting for selected_valid_o, N=%0d", $time, n);
            exp_sel.delete();
        end
        check_count("buffer_count_o", buffer_count_o, buf_count_t'(model.size()));
        step(); // keeps requests well apart
    endtask

    // m = 0, the compare process flags any valid that shows up
    task automatic empty_request();
        random_i  = $urandom;
        request_i = 1'b1;
        step();
        request_i = 1'b0;
        for (int i = 0; i < 8; i++)
            step();
        check_count("buffer_count_o", buffer_count_o, '0);
    endtask

    // fifo plays one clause per cycle, consumed because write_disable_i is low
    task automatic append_fifo(input int n);
        clause_t c;
        write_disable_i = 1'b0;
        for (int i = 0; i < n; i++) begin
            c = rand_clause();
            fifo_empty_i  = 1'b0;
            fifo_clause_i = c;
            if (model.size() < DEPTH)
                model.push_back(c);
            else
                overflow_exp = 1'b1; // dropped
            step();
        end
        fifo_empty_i = 1'b1;
        step();
        check_count("buffer_count_o", buffer_count_o, buf_count_t'(model.size()));
    endtask

    initial begin
        void'($urandom(32'h2bd80b12));
        reset            = 1'b1;
        setup_i          = 1'b0;
        ucb_setup_wren_i = 1'b0;
        ucb_setup_addr_i = '0;
        ucb_setup_data_i = '0;
        request_i        = 1'b0;
        write_disable_i  = 1'b0;
        fifo_empty_i     = 1'b1;
        fifo_clause_i    = '0;
        random_i         = '0;
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
        step();
        check_count("buffer_count_o", buffer_count_o, '0);
        check_flag("ucb_overflow_o", ucb_overflow_o, 1'b0);

        load_buffer(200);

        // fifo empty, swap-with-last removal, every 7th picks the tail
        for (int i = 0; i < 100; i++) begin
            if (i % 7 == 3)
                do_request(rand_slice_t'(model.size() - 1));
            else
                do_request(rand_slice_t'($urandom));
        end

        // fifo clause pending, appends held off so only the refill uses it
        write_disable_i = 1'b1;
        for (int i = 0; i < 20; i++) begin
            fifo_empty_i  = 1'b0;
            fifo_clause_i = rand_clause();
            do_request(rand_slice_t'($urandom));
        end
        fifo_empty_i = 1'b1;

        // appends, then a blocked stretch that must leave the count alone
        append_fifo(30);
        write_disable_i = 1'b1;
        fifo_empty_i    = 1'b0;
        fifo_clause_i   = rand_clause();
        repeat (6) step();
        fifo_empty_i    = 1'b1;
        write_disable_i = 1'b0;
        step();
        check_count("buffer_count_o", buffer_count_o, buf_count_t'(model.size()));
        for (int i = 0; i < 20; i++) begin
            if (i % 2 == 0)
                do_request(rand_slice_t'(model.size() - 1)); // recent appends
            else
                do_request(rand_slice_t'($urandom));
        end

        // drain down to m = 1, then the last one, then m = 0
        while (model.size() > 1)
            do_request(rand_slice_t'($urandom));
        do_request(rand_slice_t'($urandom));
        empty_request();

        // fill to the brim then push one more through the fifo
        load_buffer(DEPTH);
        check_flag("ucb_overflow_o", ucb_overflow_o, 1'b0);
        append_fifo(1);
        check_flag("ucb_overflow_o", ucb_overflow_o, overflow_exp);
        check_count("buffer_count_o", buffer_count_o, buf_count_t'(DEPTH));
        repeat (5) step();
        do_request(rand_slice_t'($urandom));
        check_flag("ucb_overflow_o", ucb_overflow_o, 1'b1); // sticky

        repeat (4) step();
        $display("closing counts: %0d value errors, %0d other errors", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hdl
hdl/ucs_pkg.sv
hdl/recip_table.sv
hdl/mod_index_pipe.sv
hdl/unsat_buffer_ctrl.sv
hdl/unsat_clause_ram.sv
hdl/unsat_clause_selector.sv
tb/tb_unsat_clause_selector.sv

// ==== Makefile ====
# Verilator build and run for the unsat clause selector testbench
# override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_unsat_clause_selector
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# output goes to the terminal, the pass line decides the exit status
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
